// File: Bender.yml
package:
  name: mpu_pma

sources:
  # Package first, then leaf modules, then the top level
  - rtl/mpu_pkg.sv
  - rtl/pma_region_lookup.sv
  - rtl/pma_attr_resolve.sv
  - rtl/mpu_pipe_stage.sv
  - rtl/mpu_pma.sv

  # Testbench with top module tb_mpu_pma
  - target: test
    files:
      - test/tb_mpu_pma.sv

// File: rtl/mpu_pipe_stage.sv
/* Single-entry valid/ready register stage for any payload type */

module mpu_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,

  // Upstream
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,

  // Downstream
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Free slot, or the held item leaves this cycle
  assign ready_o = !valid_q || ready_i;

  // Whenever the stage can take data, valid follows the input
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves on an input handshake
  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  //////////////////////////////////////////////////////////////////////
  // Protocol check
  //////////////////////////////////////////////////////////////////////

  // Upstream keeps a stalled item in place until it is taken
  a_hold_when_stalled : assert property (
    @(posedge clk) disable iff (!rst_n)
    valid_i && !ready_o |=> valid_i && $stable(data_i)
  ) else $error("Upstream item changed while stalled");

endmodule

// File: rtl/mpu_pkg.sv
/* Shared constants, PMA region attribute type and the request, lookup
   and response payload types of the PMA checker */

package mpu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  parameter int ADDR_W          = 32;
  parameter int MAX_PMA_REGIONS = 16;

  // Region bounds are word addresses
  parameter int WORD_ADDR_W     = ADDR_W - 2;

  //////////////////////////////////////////////////////////////////////
  // Region attributes
  //////////////////////////////////////////////////////////////////////

  // Bounds are inclusive low, exclusive high, in 32-bit words
  typedef struct packed {
    logic [WORD_ADDR_W-1:0] word_addr_low;
    logic [WORD_ADDR_W-1:0] word_addr_high;
    logic                   main;
    logic                   bufferable;
    logic                   cacheable;
    logic                   atomic;
  } pma_cfg_t;

  // Regions exist but none matched, treated as I/O
  parameter pma_cfg_t PMA_R_DEFAULT = '0;

  // No regions configured at all, everything is plain main memory
  parameter pma_cfg_t NO_PMA_R_DEFAULT = '{
    main:    1'b1,
    atomic:  1'b1,
    default: '0
  };

  // Debug module window while in debug mode
  parameter pma_cfg_t PMA_DBG_CFG = '{
    main:    1'b1,
    default: '0
  };

  //////////////////////////////////////////////////////////////////////
  // Pipeline payloads
  //////////////////////////////////////////////////////////////////////

  // Incoming memory request
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              instr;
    logic              load;
    logic              misaligned;
    logic              atomic;
    logic              dbg;
  } mpu_req_t;

  // Request with its resolved region, held in stage 1
  typedef struct packed {
    mpu_req_t req;
    pma_cfg_t cfg;
  } mpu_lookup_t;

  // Checked response, held in stage 2
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              err;
    logic              bufferable;
    logic              cacheable;
  } mpu_resp_t;

endpackage

// File: rtl/mpu_pma.sv
/* Top level of the pipelined PMA checker: region lookup, two register
   stages and attribute resolve behind loose request and response ports */

module mpu_pma #(
  parameter int NUM_REGIONS = 0,
  parameter mpu_pkg::pma_cfg_t PMA_CFG[NUM_REGIONS-1:0] = '{default: mpu_pkg::PMA_R_DEFAULT},
  parameter logic [mpu_pkg::ADDR_W-1:0] DM_REGION_START = 32'hF000_0000,
  parameter logic [mpu_pkg::ADDR_W-1:0] DM_REGION_END   = 32'hF000_3FFF,
  parameter bit IS_INSTR_SIDE = 1'b0
) (
  input  logic                       clk,
  input  logic                       rst_n,

  // Request side
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic [mpu_pkg::ADDR_W-1:0] req_addr_i,
  input  logic                       req_instr_i,
  input  logic                       req_load_i,
  input  logic                       req_misaligned_i,
  input  logic                       req_atomic_i,
  input  logic                       req_dbg_i,

  // Response side
  output logic                       resp_valid_o,
  input  logic                       resp_ready_i,
  output logic [mpu_pkg::ADDR_W-1:0] resp_addr_o,
  output logic                       resp_err_o,
  output logic                       resp_bufferable_o,
  output logic                       resp_cacheable_o
);

  mpu_pkg::mpu_req_t    req;
  mpu_pkg::mpu_lookup_t lookup_d;
  mpu_pkg::mpu_lookup_t lookup_q;
  logic                 lookup_valid;
  logic                 lookup_ready;
  mpu_pkg::mpu_resp_t   resp_d;
  mpu_pkg::mpu_resp_t   resp_q;

  assign req.addr       = req_addr_i;
  assign req.instr      = req_instr_i;
  assign req.load       = req_load_i;
  assign req.misaligned = req_misaligned_i;
  assign req.atomic     = req_atomic_i;
  assign req.dbg        = req_dbg_i;

  //////////////////////////////////////////////////////////////////////
  // Stage 1 region lookup
  //////////////////////////////////////////////////////////////////////

  pma_region_lookup #(
    .NUM_REGIONS     (NUM_REGIONS),
    .PMA_CFG         (PMA_CFG),
    .DM_REGION_START (DM_REGION_START),
    .DM_REGION_END   (DM_REGION_END)
  ) region_lookup0 (
    .req_i    (req),
    .lookup_o (lookup_d)
  );

  mpu_pipe_stage #(
    .payload_t (mpu_pkg::mpu_lookup_t)
  ) lookup_stage0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_i  (lookup_d),
    .valid_o (lookup_valid),
    .ready_i (lookup_ready),
    .data_o  (lookup_q)
  );

  //////////////////////////////////////////////////////////////////////
  // Stage 2 attribute resolve
  //////////////////////////////////////////////////////////////////////

  pma_attr_resolve #(
    .IS_INSTR_SIDE (IS_INSTR_SIDE)
  ) attr_resolve0 (
    .lookup_i (lookup_q),
    .resp_o   (resp_d)
  );

  mpu_pipe_stage #(
    .payload_t (mpu_pkg::mpu_resp_t)
  ) resp_stage0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (lookup_valid),
    .ready_o (lookup_ready),
    .data_i  (resp_d),
    .valid_o (resp_valid_o),
    .ready_i (resp_ready_i),
    .data_o  (resp_q)
  );

  assign resp_addr_o       = resp_q.addr;
  assign resp_err_o        = resp_q.err;
  assign resp_bufferable_o = resp_q.bufferable;
  assign resp_cacheable_o  = resp_q.cacheable;

endmodule

// File: rtl/pma_attr_resolve.sv
/* Error rule and bufferable/cacheable derivation from the resolved region */

module pma_attr_resolve #(
  parameter bit IS_INSTR_SIDE = 1'b0
) (
  input  mpu_pkg::mpu_lookup_t lookup_i,
  output mpu_pkg::mpu_resp_t   resp_o
);

  logic instr_err;
  logic misaligned_err;
  logic atomic_err;
  logic misaligned_atomic_err;
  logic buf_allowed;

  //////////////////////////////////////////////////////////////////////
  // Error rules
  //////////////////////////////////////////////////////////////////////

  // Fetches only from main memory
  assign instr_err      = lookup_i.req.instr && !lookup_i.cfg.main;

  // I/O regions take no split accesses
  assign misaligned_err = lookup_i.req.misaligned && !lookup_i.cfg.main;

  assign atomic_err     = lookup_i.req.atomic && !lookup_i.cfg.atomic;

  // Atomics must be naturally aligned in every region
  assign misaligned_atomic_err = lookup_i.req.misaligned && lookup_i.req.atomic;

  //////////////////////////////////////////////////////////////////////
  // Attributes
  //////////////////////////////////////////////////////////////////////

  // Loads and instruction fetches are never buffered
  assign buf_allowed = !lookup_i.req.load && !IS_INSTR_SIDE;

  assign resp_o.addr       = lookup_i.req.addr;
  assign resp_o.err        = instr_err || misaligned_err ||
                             atomic_err || misaligned_atomic_err;
  assign resp_o.bufferable = lookup_i.cfg.bufferable && buf_allowed;
  assign resp_o.cacheable  = lookup_i.cfg.cacheable;

endmodule

// File: rtl/pma_region_lookup.sv
/* Address to PMA region priority match, with the debug window override */

module pma_region_lookup #(
  parameter int NUM_REGIONS = 0,
  parameter mpu_pkg::pma_cfg_t PMA_CFG[NUM_REGIONS-1:0] = '{default: mpu_pkg::PMA_R_DEFAULT},
  parameter logic [mpu_pkg::ADDR_W-1:0] DM_REGION_START = 32'hF000_0000,
  parameter logic [mpu_pkg::ADDR_W-1:0] DM_REGION_END   = 32'hF000_3FFF
) (
  input  mpu_pkg::mpu_req_t    req_i,
  output mpu_pkg::mpu_lookup_t lookup_o
);

  logic              region_hit;
  mpu_pkg::pma_cfg_t region_cfg;
  logic              dbg_hit;
  mpu_pkg::pma_cfg_t resolved_cfg;

  // Bits [1:0] of the address never take part in the compare
  function automatic logic addr_in_region(
    input mpu_pkg::pma_cfg_t        cfg,
    input logic [mpu_pkg::ADDR_W-1:0] addr
  );
    logic lo_ok;
    logic hi_ok;
    lo_ok = {cfg.word_addr_low, 2'b00} <= addr;
    hi_ok = addr < {cfg.word_addr_high, 2'b00};
    return lo_ok && hi_ok;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Region scan
  //////////////////////////////////////////////////////////////////////

  // Lowest index wins when regions overlap
  always_comb begin
    region_hit = 1'b0;
    region_cfg = mpu_pkg::PMA_R_DEFAULT;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (!region_hit && addr_in_region(PMA_CFG[i], req_i.addr)) begin
        region_hit = 1'b1;
        region_cfg = PMA_CFG[i];
      end
    end
  end

  // Debug window is inclusive at both ends
  assign dbg_hit = req_i.dbg &&
                   (req_i.addr >= DM_REGION_START) &&
                   (req_i.addr <= DM_REGION_END);

  always_comb begin
    if (dbg_hit) begin
      resolved_cfg = mpu_pkg::PMA_DBG_CFG;
    end else if (NUM_REGIONS == 0) begin
      resolved_cfg = mpu_pkg::NO_PMA_R_DEFAULT;
    end else if (region_hit) begin
      resolved_cfg = region_cfg;
    end else begin
      resolved_cfg = mpu_pkg::PMA_R_DEFAULT;
    end
  end

  assign lookup_o.req = req_i;
  assign lookup_o.cfg = resolved_cfg;

  //////////////////////////////////////////////////////////////////////
  // Table checks
  //////////////////////////////////////////////////////////////////////

  if (NUM_REGIONS > mpu_pkg::MAX_PMA_REGIONS) begin : g_bad_num_regions
    $fatal(1, "PMA region count %0d above limit %0d", NUM_REGIONS,
           mpu_pkg::MAX_PMA_REGIONS);
  end

  // I/O regions can never be cacheable
  for (genvar i = 0; i < NUM_REGIONS; i++) begin : g_cfg_check
    if (!PMA_CFG[i].main && PMA_CFG[i].cacheable) begin : g_io_cacheable
      $fatal(1, "PMA region %0d is I/O and cacheable", i);
    end
  end

endmodule

// File: test/tb_mpu_pma.sv
/* Testbench for the pipelined PMA checker: clock, reset, DUT instance,
   reference model of the region and error rules, directed tests */

module tb_mpu_pma;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          WAIT_LIMIT = 500;
  localparam logic [31:0] SEED       = 32'd64119;
  localparam logic [31:0] DBG_START  = 32'hF000_0000;
  localparam logic [31:0] DBG_END    = 32'hF000_3FFF;

  // Region table in byte addresses, attributes as {main, buf, cache, atomic}
  localparam logic [31:0] REGION_BASE  [3] = '{32'h1000_0000, 32'h1800_0000, 32'h4000_0000};
  localparam logic [31:0] REGION_LIMIT [3] = '{32'h2000_0000, 32'h2800_0000, 32'h5000_0000};
  localparam logic [3:0]  REGION_ATTR  [3] = '{4'b1010, 4'b1101, 4'b0000};

  localparam mpu_pkg::pma_cfg_t PMA_TABLE [2:0] = '{
    0: {REGION_BASE[0][31:2], REGION_LIMIT[0][31:2], REGION_ATTR[0]},
    1: {REGION_BASE[1][31:2], REGION_LIMIT[1][31:2], REGION_ATTR[1]},
    2: {REGION_BASE[2][31:2], REGION_LIMIT[2][31:2], REGION_ATTR[2]}
  };

  logic        clk;
  logic        rst_n;
  logic        req_valid_i;
  logic        req_ready_o;
  logic [31:0] req_addr_i;
  logic        req_instr_i;
  logic        req_load_i;
  logic        req_misaligned_i;
  logic        req_atomic_i;
  logic        req_dbg_i;
  logic        resp_valid_o;
  logic        resp_ready_i;
  logic [31:0] resp_addr_o;
  logic        resp_err_o;
  logic        resp_bufferable_o;
  logic        resp_cacheable_o;

  mpu_pkg::mpu_resp_t pending[$];
  mpu_pkg::mpu_resp_t popped_resp;
  int                 error_count;
  int                 check_count;
  int                 req_count;
  int                 resp_count;
  logic [31:0]        req_state;
  logic [31:0]        stall_state;
  logic               stream_done;

  mpu_pma #(
    .NUM_REGIONS     (3),
    .PMA_CFG         (PMA_TABLE),
    .DM_REGION_START (DBG_START),
    .DM_REGION_END   (DBG_END),
    .IS_INSTR_SIDE   (1'b0)
  ) dut0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .req_valid_i       (req_valid_i),
    .req_ready_o       (req_ready_o),
    .req_addr_i        (req_addr_i),
    .req_instr_i       (req_instr_i),
    .req_load_i        (req_load_i),
    .req_misaligned_i  (req_misaligned_i),
    .req_atomic_i      (req_atomic_i),
    .req_dbg_i         (req_dbg_i),
    .resp_valid_o      (resp_valid_o),
    .resp_ready_i      (resp_ready_i),
    .resp_addr_o       (resp_addr_o),
    .resp_err_o        (resp_err_o),
    .resp_bufferable_o (resp_bufferable_o),
    .resp_cacheable_o  (resp_cacheable_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Debug window first, then lowest matching region, else all attributes clear
  function automatic mpu_pkg::mpu_resp_t expected_resp(input logic [31:0] addr,
      input logic instr, input logic load, input logic mis, input logic atomic,
      input logic dbg);
    mpu_pkg::mpu_resp_t r;
    logic [3:0]         attr;
    logic               found;
    attr  = 4'b0000;
    found = 1'b0;
    if (dbg && addr >= DBG_START && addr <= DBG_END) begin
      attr = 4'b1000;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (!found && addr >= REGION_BASE[i] && addr < REGION_LIMIT[i]) begin
          found = 1'b1;
          attr  = REGION_ATTR[i];
        end
      end
    end
    r.addr       = addr;
    r.err        = (instr && !attr[3]) || (mis && !attr[3]) ||
                   (atomic && !attr[0]) || (mis && atomic);
    r.bufferable = attr[2] && !load;
    r.cacheable  = attr[1];
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] want);
    check_count++;
    assert (got === want) else begin
      $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, want);
      error_count++;
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("Test %-14s finished with %0d errors", name, error_count - errors_before);
  endtask

  // Response and request handshakes, seen half a cycle before the edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (resp_valid_o && resp_ready_i) begin
        resp_count++;
        assert (pending.size() != 0) else begin
          $display("Response for address %h arrived with no request outstanding",
                   resp_addr_o);
          error_count++;
        end
        if (pending.size() != 0) begin
          popped_resp = pending.pop_front();
          check_value("resp_addr_o", resp_addr_o, popped_resp.addr);
          check_value("resp_err_o", resp_err_o, popped_resp.err);
          check_value("resp_bufferable_o", resp_bufferable_o, popped_resp.bufferable);
          check_value("resp_cacheable_o", resp_cacheable_o, popped_resp.cacheable);
        end
      end
      if (req_valid_i && req_ready_o) begin
        req_count++;
        pending.push_back(expected_resp(req_addr_i, req_instr_i, req_load_i,
                                        req_misaligned_i, req_atomic_i, req_dbg_i));
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////////////////////////

  // Called at a rising edge, returns at the edge that takes the request
  task automatic send_req(input logic [31:0] addr, input logic instr, input logic load,
      input logic mis, input logic atomic, input logic dbg);
    int waited;
    waited           = 0;
    req_valid_i      <= 1'b1;
    req_addr_i       <= addr;
    req_instr_i      <= instr;
    req_load_i       <= load;
    req_misaligned_i <= mis;
    req_atomic_i     <= atomic;
    req_dbg_i        <= dbg;
    do begin
      @(posedge clk);
      waited++;
    end while (!req_ready_o && waited < WAIT_LIMIT);
    if (!req_ready_o) begin
      timeout_fail("req_ready_o");
    end
  endtask

  task automatic idle_req();
    req_valid_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((pending.size() != 0 || resp_valid_o) && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (pending.size() != 0 || resp_valid_o) begin
      timeout_fail("outstanding responses");
    end
  endtask

  // Kind 0 fetch, 1 load, 2 store, 3 misaligned store, 4 atomic
  task automatic access(input logic [31:0] addr, input int kind, input logic dbg);
    send_req(addr, kind == 0, kind == 1, kind == 3, kind == 4, dbg);
    idle_req();
    wait_drain();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    int errors_before;
    errors_before = error_count;
    @(negedge clk);
    check_value("resp_valid_o", resp_valid_o, 1'b0);
    check_value("req_ready_o", req_ready_o, 1'b1);
    @(posedge clk);
    report_test("reset_state", errors_before);
  endtask

  task automatic test_region_attrs();
    int errors_before;
    logic [31:0] addrs [3];
    errors_before = error_count;
    addrs = '{32'h1000_0040, 32'h2000_1000, 32'h4000_0100};
    foreach (addrs[i]) begin
      for (int kind = 0; kind < 5; kind++) begin
        access(addrs[i], kind, 1'b0);
      end
    end
    report_test("region_attrs", errors_before);
  endtask

  // Region 0 has no atomics and no buffering, region 1 has both
  task automatic test_priority();
    int errors_before;
    errors_before = error_count;
    for (int kind = 0; kind < 5; kind++) begin
      access(32'h1800_0000, kind, 1'b0);
      access(32'h1FFF_FFFC, kind, 1'b0);
    end
    report_test("priority", errors_before);
  endtask

  task automatic test_default();
    int errors_before;
    logic [31:0] addrs [3];
    errors_before = error_count;
    addrs = '{32'h0000_1000, 32'h3000_0000, 32'h6000_0000};
    foreach (addrs[i]) begin
      for (int kind = 0; kind < 5; kind++) begin
        access(addrs[i], kind, 1'b0);
      end
    end
    report_test("default", errors_before);
  endtask

  task automatic test_debug_window();
    int errors_before;
    errors_before = error_count;
    access(32'hF000_0100, 0, 1'b1);
    access(32'hF000_0100, 0, 1'b0);
    access(32'hF000_0100, 4, 1'b1);
    access(DBG_START, 1, 1'b1);
    access(DBG_END, 2, 1'b1);
    access(DBG_END + 32'd1, 0, 1'b1);
    report_test("debug_window", errors_before);
  endtask

  task automatic test_backpressure();
    int          errors_before;
    int          req_before;
    int          resp_before;
    logic [31:0] r;
    logic [31:0] offset;
    logic [31:0] addr;
    errors_before = error_count;
    req_before    = req_count;
    resp_before   = resp_count;
    stream_done   = 1'b0;
    fork
      begin
        for (int n = 0; n < 40; n++) begin
          req_state = xorshift(req_state);
          r         = req_state;
          offset    = {14'd0, r[27:12], 2'b00};
          case (r[2:0])
            3'd0:    addr = 32'h1000_0000 + offset;
            3'd1:    addr = 32'h1800_0000 + offset;
            3'd2:    addr = 32'h2000_0000 + offset;
            3'd3:    addr = 32'h4000_0000 + offset;
            3'd4:    addr = 32'h3000_0000 + offset;
            3'd5:    addr = DBG_START + (offset & 32'h3FFF);
            3'd6:    addr = 32'h27FF_F000 + (offset & 32'hFFF);
            default: addr = 32'h0000_0000 + offset;
          endcase
          send_req(addr, r[28], r[29], r[30], r[31], r[4] | r[5]);
          if (r[20]) begin
            idle_req();
            @(posedge clk);
          end
        end
        idle_req();
        stream_done = 1'b1;
      end
      begin
        for (int c = 0; c < 4 * WAIT_LIMIT && !stream_done; c++) begin
          @(posedge clk);
          stall_state = xorshift(stall_state);
          resp_ready_i <= stall_state[7];
        end
        resp_ready_i <= 1'b1;
      end
    join
    wait_drain();
    assert (req_count - req_before == 40 && resp_count - resp_before == 40) else begin
      $display("Stream of 40 requests gave %0d accepted and %0d responses",
               req_count - req_before, resp_count - resp_before);
      error_count++;
    end
    report_test("backpressure", errors_before);
  endtask

  initial begin
    rst_n            = 1'b0;
    req_valid_i      = 1'b0;
    req_addr_i       = '0;
    req_instr_i      = 1'b0;
    req_load_i       = 1'b0;
    req_misaligned_i = 1'b0;
    req_atomic_i     = 1'b0;
    req_dbg_i        = 1'b0;
    resp_ready_i     = 1'b1;
    error_count      = 0;
    check_count      = 0;
    req_count        = 0;
    resp_count       = 0;
    stream_done      = 1'b0;
    req_state        = SEED;
    stall_state      = xorshift(SEED ^ 32'h5A5A_0F0F);
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    test_reset_state();
    test_region_attrs();
    test_priority();
    test_default();
    test_debug_window();
    test_backpressure();
    $display("Summary: %0d checks, %0d errors, %0d requests, %0d responses",
             check_count, error_count, req_count, resp_count);
    if (error_count == 0 && pending.size() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
rtl/mpu_pkg.sv
rtl/pma_region_lookup.sv
rtl/pma_attr_resolve.sv
rtl/mpu_pipe_stage.sv
rtl/mpu_pma.sv
test/tb_mpu_pma.sv
